// File: rtl/cpuPkg.sv
/* machine-wide widths, word types and memory depths for the 16-bit core
   every block reaches these by scoped name */
`default_nettype none

package cpuPkg;
  // datapath and register index widths
  localparam int wordWidth = 16;
  localparam int regAddrWidth = 4;
  localparam int flagWidth = 3;

  // storage sizes, all in words
  localparam int numRegs = 16;
  localparam int imemDepth = 256;
  localparam int dmemDepth = 256;

  // index widths into the two memories
  localparam int imemAddrWidth = $clog2(imemDepth);
  localparam int dmemAddrWidth = $clog2(dmemDepth);

  typedef logic [wordWidth-1:0] word;
  // instruction address, only the low imemAddrWidth bits reach the memory
  typedef logic [wordWidth-1:0] pcAddr;
  typedef logic [regAddrWidth-1:0] regAddr;
  typedef logic [flagWidth-1:0] flagVec;
endpackage

`default_nettype wire

// File: rtl/isaPkg.sv
/* instruction set encodings: opcodes, decoder select codes, branch conditions
   and the bit positions of the instruction fields */
`default_nettype none

package isaPkg;
  typedef enum logic [3:0] {
    opAdd = 4'd0, opSub, opRed, opXor,
    opSll, opSra, opRor, opPaddsb,
    opLw, opSw, opLhb, opLlb,
    opB, opBr, opPcs, opHlt
  } opcode;

  // how the immediate is formatted out of the low instruction bits
  typedef enum logic [1:0] {imm4, imm9, immLow, immHigh} immSel;

  // write-back source
  typedef enum logic [1:0] {fromMem, fromPc, fromImm, fromAlu} dataSel;

  // next-pc source, regTarget is the resolved BR code
  typedef enum logic [1:0] {seqPc, immTarget, regTarget} branchSel;

  // branch conditions in ccc field order
  typedef enum logic [2:0] {
    condNe, condEq, condGt, condLt, condGe, condLe, condOv, condAlways
  } cond;

  // flag register bit positions
  localparam int flagZ = 2;
  localparam int flagV = 1;
  localparam int flagN = 0;

  // instruction field positions
  localparam int opcodeHi = 15;
  localparam int opcodeLo = 12;
  localparam int slot1Hi = 11;
  localparam int slot1Lo = 8;
  localparam int slot2Hi = 7;
  localparam int slot2Lo = 4;
  localparam int slot3Hi = 3;
  localparam int slot3Lo = 0;
  localparam int condHi = 11;
  localparam int condLo = 9;
  // top bit of the B offset
  localparam int imm9Hi = 8;
endpackage

`default_nettype wire

// File: rtl/ctrlBus.sv
/* decoded control and operand fields, driven by the decoder and read by the
   register file and the execute-side blocks */
`timescale 1ns/1ps
`default_nettype none

interface ctrlBus;
  logic regWrite;
  logic memRead;
  logic memWrite;
  logic aluSrc;
  isaPkg::dataSel dataSrc;
  isaPkg::branchSel branchSrc;
  isaPkg::opcode op;
  isaPkg::cond cond;
  cpuPkg::regAddr readReg1;
  cpuPkg::regAddr readReg2;
  cpuPkg::regAddr writeReg;
  cpuPkg::word imm;
  // high only while running, gates every state update
  logic exec;

  modport dec (
    output regWrite, memRead, memWrite, aluSrc, dataSrc, branchSrc,
    output op, cond, readReg1, readReg2, writeReg, imm, exec
  );
  // op tells LHB from LLB for the byte merge
  modport rf (input readReg1, readReg2, writeReg, regWrite, dataSrc, imm, op, exec);
  modport ex (input aluSrc, op, imm, memRead, memWrite, branchSrc, cond, exec);
endinterface

`default_nettype wire

// File: rtl/control.sv
/* opcode decoder for the single-cycle core, plus the idle/run/halt machine
   that produces exec and halted */
`timescale 1ns/1ps
`default_nettype none

module control (
  input wire logic clk,
  input wire logic rstN,
  input wire logic run,
  input wire cpuPkg::word instr,
  output logic halted,
  ctrlBus.dec bus
);
  typedef enum logic [1:0] {stIdle, stRun, stHalt} runState;

  isaPkg::opcode op;
  isaPkg::immSel immSel;
  logic isShift;
  logic isMem;
  logic regSrc;
  runState state;

  assign op = isaPkg::opcode'(instr[isaPkg::opcodeHi:isaPkg::opcodeLo]);

  assign isShift = (op == isaPkg::opSll) || (op == isaPkg::opSra) || (op == isaPkg::opRor);
  // 10xx covers LW, SW, LHB and LLB
  assign isMem = op[3] && !op[2];

  // slot 1 feeds read port 2 for SW and for the byte loads
  assign regSrc = (op == isaPkg::opSw) || (op == isaPkg::opLhb) || (op == isaPkg::opLlb);

  assign bus.op = op;
  assign bus.memRead = (op == isaPkg::opLw);
  assign bus.memWrite = (op == isaPkg::opSw);
  // immediate needed by shifts and 10xx
  assign bus.aluSrc = isShift || isMem;
  // every 0xxx, plus LW, LHB, LLB and PCS
  assign bus.regWrite = !op[3] || (op == isaPkg::opLw) || (op == isaPkg::opLhb) ||
                        (op == isaPkg::opLlb) || (op == isaPkg::opPcs);

  // register fields
  assign bus.readReg1 = instr[isaPkg::slot2Hi:isaPkg::slot2Lo];
  assign bus.readReg2 = regSrc ? instr[isaPkg::slot1Hi:isaPkg::slot1Lo] :
                                 instr[isaPkg::slot3Hi:isaPkg::slot3Lo];
  assign bus.writeReg = instr[isaPkg::slot1Hi:isaPkg::slot1Lo];
  assign bus.cond = isaPkg::cond'(instr[isaPkg::condHi:isaPkg::condLo]);

  always_comb begin
    if (isShift || (op == isaPkg::opLw) || (op == isaPkg::opSw)) begin
      immSel = isaPkg::imm4;
    end else if (op == isaPkg::opB) begin
      immSel = isaPkg::imm9;
    end else if (op == isaPkg::opLlb) begin
      immSel = isaPkg::immLow;
    end else begin
      immSel = isaPkg::immHigh;
    end
  end

  // immediate formatting
  always_comb begin
    unique case (immSel)
      isaPkg::imm4: begin
        bus.imm = {{12{instr[isaPkg::slot3Hi]}}, instr[isaPkg::slot3Hi:isaPkg::slot3Lo]};
      end
      isaPkg::imm9: begin
        bus.imm = {{7{instr[isaPkg::imm9Hi]}}, instr[isaPkg::imm9Hi:0]};
      end
      isaPkg::immLow: begin
        bus.imm = {8'h00, instr[isaPkg::slot2Hi:isaPkg::slot3Lo]};
      end
      default: begin
        bus.imm = {instr[isaPkg::slot2Hi:isaPkg::slot3Lo], 8'h00};
      end
    endcase
  end

  // write-back and next-pc sources
  always_comb begin
    bus.dataSrc = isaPkg::fromAlu;
    if (op == isaPkg::opLw) begin
      bus.dataSrc = isaPkg::fromMem;
    end else if (op == isaPkg::opPcs) begin
      bus.dataSrc = isaPkg::fromPc;
    end else if ((op == isaPkg::opLlb) || (op == isaPkg::opLhb)) begin
      bus.dataSrc = isaPkg::fromImm;
    end
    bus.branchSrc = isaPkg::seqPc;
    if (op == isaPkg::opB) begin
      bus.branchSrc = isaPkg::immTarget;
    end else if (op == isaPkg::opBr) begin
      bus.branchSrc = isaPkg::regTarget;
    end
  end

  // run level leaves idle, HLT parks until reset
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= stIdle;
    end else begin
      unique case (state)
        stIdle: begin
          if (run) begin
            state <= stRun;
          end
        end
        stRun: begin
          if (op == isaPkg::opHlt) begin
            state <= stHalt;
          end
        end
        default: begin
          state <= stHalt;
        end
      endcase
    end
  end

  assign bus.exec = (state == stRun);
  assign halted = (state == stHalt);
endmodule

`default_nettype wire

// File: rtl/fetchUnit.sv
/* instruction memory, program counter and branch resolution
   the memory is loaded from top-level ports, the pc moves only while running */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
  input wire logic clk,
  input wire logic rstN,
  input wire logic imemWe,
  input wire cpuPkg::pcAddr imemAddr,
  input wire cpuPkg::word imemData,
  input wire cpuPkg::flagVec flags,
  input wire cpuPkg::word regTarget,
  ctrlBus.ex bus,
  output cpuPkg::word instr,
  output cpuPkg::pcAddr pcNext
);
  cpuPkg::word imem [cpuPkg::imemDepth];
  cpuPkg::pcAddr pc;
  cpuPkg::pcAddr pcTarget;
  logic taken;

  // loads accepted in any state
  always_ff @(posedge clk) begin
    if (imemWe) begin
      imem[imemAddr[cpuPkg::imemAddrWidth-1:0]] <= imemData;
    end
  end

  assign instr = imem[pc[cpuPkg::imemAddrWidth-1:0]];
  // word addressed, one step per instruction
  assign pcNext = pc + 16'd1;

  // condition test against Z/V/N
  always_comb begin
    unique case (bus.cond)
      isaPkg::condNe: taken = !flags[isaPkg::flagZ];
      isaPkg::condEq: taken = flags[isaPkg::flagZ];
      isaPkg::condGt: taken = !flags[isaPkg::flagZ] && !flags[isaPkg::flagN];
      isaPkg::condLt: taken = flags[isaPkg::flagN];
      isaPkg::condGe: taken = flags[isaPkg::flagZ] || !flags[isaPkg::flagN];
      isaPkg::condLe: taken = flags[isaPkg::flagZ] || flags[isaPkg::flagN];
      isaPkg::condOv: taken = flags[isaPkg::flagV];
      isaPkg::condAlways: taken = 1'b1;
    endcase
  end

  always_comb begin
    pcTarget = pcNext;
    if (taken && (bus.branchSrc == isaPkg::immTarget)) begin
      // B offset is relative to the sequential pc
      pcTarget = pcNext + bus.imm;
    end else if (taken && (bus.branchSrc == isaPkg::regTarget)) begin
      pcTarget = regTarget;
    end
  end

  // idle is only reached through reset, so pc sits at 0 there
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
    end else if (bus.exec) begin
      pc <= pcTarget;
    end
  end
endmodule

`default_nettype wire

// File: rtl/regFile.sv
/* sixteen-entry register file with write-back select
   r0 is never written and reads as zero */
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input wire logic clk,
  input wire logic rstN,
  ctrlBus.rf bus,
  input wire cpuPkg::word aluResult,
  input wire cpuPkg::word memData,
  input wire cpuPkg::pcAddr pcNext,
  output cpuPkg::word rd1,
  output cpuPkg::word rd2,
  output logic wbEn,
  output cpuPkg::regAddr wbReg,
  output cpuPkg::word wbData
);
  cpuPkg::word regs [cpuPkg::numRegs];
  cpuPkg::word merged;
  cpuPkg::word wdata;

  assign rd1 = regs[bus.readReg1];
  assign rd2 = regs[bus.readReg2];

  // rd2 holds the destination's old value for LHB/LLB
  assign merged = (bus.op == isaPkg::opLhb) ? {bus.imm[15:8], rd2[7:0]} :
                                              {rd2[15:8], bus.imm[7:0]};

  always_comb begin
    unique case (bus.dataSrc)
      isaPkg::fromMem: wdata = memData;
      isaPkg::fromPc: wdata = pcNext;
      isaPkg::fromImm: wdata = merged;
      isaPkg::fromAlu: wdata = aluResult;
    endcase
  end

  // trace shows the commit of this cycle
  assign wbEn = bus.exec && bus.regWrite;
  assign wbReg = bus.writeReg;
  assign wbData = wdata;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < cpuPkg::numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEn && (bus.writeReg != '0)) begin
      regs[bus.writeReg] <= wdata;
    end
  end
endmodule

`default_nettype wire

// File: rtl/alu.sv
/* arithmetic, logic and shift unit with the Z/V/N flag register
   also forms the data memory address for LW and SW */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input wire logic clk,
  input wire logic rstN,
  ctrlBus.ex bus,
  input wire cpuPkg::word rd1,
  input wire cpuPkg::word rd2,
  output cpuPkg::word result,
  output cpuPkg::flagVec flags
);
  cpuPkg::word opB;
  cpuPkg::word sum;
  cpuPkg::word diff;
  cpuPkg::word red;
  cpuPkg::word padd;
  logic [31:0] rorWide;
  logic [3:0] shamt;
  logic sumOvf;
  logic diffOvf;

  // signed 4-bit add, clamped to 7 / -8
  function automatic logic [3:0] satNibble(logic [3:0] a, logic [3:0] b);
    logic [3:0] s;
    s = a + b;
    if ((a[3] == b[3]) && (s[3] != a[3])) begin
      satNibble = a[3] ? 4'h8 : 4'h7;
    end else begin
      satNibble = s;
    end
  endfunction

  assign opB = bus.aluSrc ? bus.imm : rd2;
  assign shamt = opB[3:0];

  assign sum = rd1 + opB;
  assign diff = rd1 - opB;
  // signed overflow
  assign sumOvf = (rd1[15] == opB[15]) && (sum[15] != rd1[15]);
  assign diffOvf = (rd1[15] != opB[15]) && (diff[15] != rd1[15]);

  // four signed nibbles of rd1, summed
  assign red = {{12{rd1[3]}}, rd1[3:0]} + {{12{rd1[7]}}, rd1[7:4]} +
               {{12{rd1[11]}}, rd1[11:8]} + {{12{rd1[15]}}, rd1[15:12]};

  // doubled word, so a zero rotate stays clean
  assign rorWide = {rd1, rd1} >> shamt;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      padd[4*i +: 4] = satNibble(rd1[4*i +: 4], opB[4*i +: 4]);
    end
  end

  always_comb begin
    unique case (bus.op)
      isaPkg::opAdd: result = sumOvf ? (rd1[15] ? 16'h8000 : 16'h7fff) : sum;
      isaPkg::opSub: result = diffOvf ? (rd1[15] ? 16'h8000 : 16'h7fff) : diff;
      isaPkg::opRed: result = red;
      isaPkg::opXor: result = rd1 ^ opB;
      isaPkg::opSll: result = rd1 << shamt;
      isaPkg::opSra: result = $signed(rd1) >>> shamt;
      isaPkg::opRor: result = rorWide[15:0];
      isaPkg::opPaddsb: result = padd;
      // byte address from a word offset
      isaPkg::opLw, isaPkg::opSw: result = rd1 + (opB << 1);
      default: result = '0;
    endcase
  end

  // arithmetic sets all three, XOR and shifts only Z
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (bus.exec) begin
      case (bus.op)
        isaPkg::opAdd, isaPkg::opSub: begin
          flags[isaPkg::flagZ] <= (result == '0);
          flags[isaPkg::flagV] <= (bus.op == isaPkg::opSub) ? diffOvf : sumOvf;
          flags[isaPkg::flagN] <= result[15];
        end
        isaPkg::opXor, isaPkg::opSll, isaPkg::opSra, isaPkg::opRor: begin
          flags[isaPkg::flagZ] <= (result == '0);
        end
        default: begin
          flags <= flags;
        end
      endcase
    end
  end
endmodule

`default_nettype wire

// File: rtl/dataMem.sv
/* word-organised data memory, byte addressed from the ALU
   read is combinational, write lands on the clock edge */
`timescale 1ns/1ps
`default_nettype none

module dataMem (
  input wire logic clk,
  ctrlBus.ex bus,
  input wire cpuPkg::word addr,
  input wire cpuPkg::word wdata,
  output cpuPkg::word rdata
);
  cpuPkg::word mem [cpuPkg::dmemDepth];
  logic [cpuPkg::dmemAddrWidth-1:0] index;

  // drop the byte bit
  assign index = addr[cpuPkg::dmemAddrWidth:1];

  always_ff @(posedge clk) begin
    if (bus.exec && bus.memWrite) begin
      mem[index] <= wdata;
    end
  end

  // quiet unless a load is decoded
  assign rdata = bus.memRead ? mem[index] : '0;
endmodule

`default_nettype wire

// File: rtl/cpuTop.sv
/* single-cycle 16-bit core: decoder plus fetch, register file, ALU and data memory
   program is loaded over imemWe/imemAddr/imemData, run starts it, HLT stops it */
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
  input wire logic clk,
  input wire logic rstN,
  input wire logic run,
  input wire logic imemWe,
  input wire cpuPkg::pcAddr imemAddr,
  input wire cpuPkg::word imemData,
  output logic halted,
  output logic wbEn,
  output cpuPkg::regAddr wbReg,
  output cpuPkg::word wbData
);
  cpuPkg::word instr;
  cpuPkg::pcAddr pcNext;
  cpuPkg::flagVec flags;
  cpuPkg::word rd1;
  cpuPkg::word rd2;
  cpuPkg::word aluResult;
  cpuPkg::word memData;

  ctrlBus ctrl ();

  control uControl (
    .clk(clk),
    .rstN(rstN),
    .run(run),
    .instr(instr),
    .halted(halted),
    .bus(ctrl.dec)
  );

  // BR target comes from read port 1
  fetchUnit uFetch (
    .clk(clk),
    .rstN(rstN),
    .imemWe(imemWe),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .flags(flags),
    .regTarget(rd1),
    .bus(ctrl.ex),
    .instr(instr),
    .pcNext(pcNext)
  );

  regFile uRegs (
    .clk(clk),
    .rstN(rstN),
    .bus(ctrl.rf),
    .aluResult(aluResult),
    .memData(memData),
    .pcNext(pcNext),
    .rd1(rd1),
    .rd2(rd2),
    .wbEn(wbEn),
    .wbReg(wbReg),
    .wbData(wbData)
  );

  alu uAlu (
    .clk(clk),
    .rstN(rstN),
    .bus(ctrl.ex),
    .rd1(rd1),
    .rd2(rd2),
    .result(aluResult),
    .flags(flags)
  );

  // SW stores read port 2, which carries slot 1
  dataMem uDmem (
    .clk(clk),
    .bus(ctrl.ex),
    .addr(aluResult),
    .wdata(rd2),
    .rdata(memData)
  );
endmodule

`default_nettype wire

// File: bench/tbClock.sv
/* clock and reset source for the core testbench
   4 ns clock, reset low for five cycles at start and after each restart pulse */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
  input wire logic restart,
  output logic clk,
  output logic rstN
);
  localparam int resetCycles = 5;

  // cycles of reset still to run
  int lowLeft = resetCycles;

  always begin
    clk = 1'b0;
    #2;
    clk = 1'b1;
    #2;
  end

  // restart reloads the count
  always @(posedge clk) begin
    if (restart) begin
      lowLeft <= resetCycles;
    end else if (lowLeft != 0) begin
      lowLeft <= lowLeft - 1;
    end
  end

  assign rstN = (lowLeft == 0);
endmodule

`default_nettype wire

// File: bench/cpuTb.sv
/* testbench for the single-cycle core that loads each program from bench/cpuCases.txt,
   runs it to HLT and checks the write-back trace against the expected pairs */
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
  localparam int imageDepth = 1024;
  localparam int cyclesPerCase = 64;
  localparam int drainCycles = 4;
  // record kinds in the cases file
  localparam logic [15:0] recInstr = 16'd1;
  localparam logic [15:0] recExpect = 16'd2;
  localparam logic [15:0] recEnd = 16'd3;

  logic clk;
  logic rstN;
  logic restart;
  logic run;
  logic imemWe;
  cpuPkg::pcAddr imemAddr;
  cpuPkg::word imemData;
  logic halted;
  logic wbEn;
  cpuPkg::regAddr wbReg;
  cpuPkg::word wbData;

  // three words per record of kind, address or register and value
  logic [15:0] image [imageDepth];
  int cursor = 0;
  cpuPkg::pcAddr loadAddr [$];
  cpuPkg::word loadData [$];
  cpuPkg::regAddr expReg [$];
  cpuPkg::word expVal [$];

  int numCases = 0;
  int cycleLimit = 0;
  int mismatches = 0;
  int otherErrors = 0;

  tbClock clkGen (.restart(restart), .clk(clk), .rstN(rstN));

  cpuTop DUT (
    .clk(clk),
    .rstN(rstN),
    .run(run),
    .imemWe(imemWe),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .halted(halted),
    .wbEn(wbEn),
    .wbReg(wbReg),
    .wbData(wbData)
  );

  // complete cases up to the first zero kind
  function automatic int countCases();
    int n;
    int q;
    n = 0;
    q = 0;
    while ((q + 2 < imageDepth) && (image[q] != 16'h0)) begin
      if (image[q] == recEnd) begin
        n++;
      end
      q += 3;
    end
    return n;
  endfunction

  // one case worth of records into the queues
  task automatic gatherCase();
    loadAddr.delete();
    loadData.delete();
    expReg.delete();
    expVal.delete();
    while ((cursor + 2 < imageDepth) && (image[cursor] != recEnd)) begin
      if (image[cursor] == recInstr) begin
        loadAddr.push_back(image[cursor+1]);
        loadData.push_back(image[cursor+2]);
      end else if (image[cursor] == recExpect) begin
        expReg.push_back(image[cursor+1][3:0]);
        expVal.push_back(image[cursor+2]);
      end else begin
        otherErrors++;
        $display("unknown record kind %h at image word %0d", image[cursor], cursor);
      end
      cursor += 3;
    end
    // past the end marker
    cursor += 3;
  endtask

  task automatic printCounts();
    $display("cases: %0d, mismatches: %0d, other errors: %0d",
             numCases, mismatches, otherErrors);
  endtask

  task automatic resetCore();
    @(posedge clk);
    restart <= 1'b1;
    run <= 1'b0;
    imemWe <= 1'b0;
    @(posedge clk);
    restart <= 1'b0;
    @(negedge clk);
    while (!rstN) begin
      @(negedge clk);
    end
    assert (!halted && !wbEn) else begin
      otherErrors++;
      $display("core not idle after reset at %0t", $time);
    end
  endtask

  // idle core must stay quiet while the program goes in
  task automatic loadProgram(input int caseNo);
    for (int i = 0; i < loadAddr.size(); i++) begin
      @(posedge clk);
      imemWe <= 1'b1;
      imemAddr <= loadAddr[i];
      imemData <= loadData[i];
      @(negedge clk);
      assert (!wbEn && !halted) else begin
        otherErrors++;
        $display("case %0d: core active during load at %0t", caseNo, $time);
      end
    end
    @(posedge clk);
    imemWe <= 1'b0;
  endtask

  task automatic checkWriteBack(input int caseNo, input int idx);
    assert (idx < expReg.size()) else begin
      mismatches++;
      $display("MISMATCH at %0t: case %0d unexpected write-back r%0d = %h",
               $time, caseNo, wbReg, wbData);
    end
    if (idx < expReg.size()) begin
      assert ((wbReg == expReg[idx]) && (wbData == expVal[idx])) else begin
        mismatches++;
        $display("MISMATCH at %0t: case %0d write-back %0d is r%0d = %h, expected r%0d = %h",
                 $time, caseNo, idx, wbReg, wbData, expReg[idx], expVal[idx]);
      end
    end
  endtask

  task automatic runProgram(input int caseNo);
    int seen;
    seen = 0;
    @(posedge clk);
    run <= 1'b1;
    // sample mid-cycle while the trace shows the coming commit
    do begin
      @(negedge clk);
      if (wbEn) begin
        checkWriteBack(caseNo, seen);
        seen++;
      end
    end while (!halted);
    // halted must hold with a silent trace
    for (int i = 0; i < drainCycles; i++) begin
      @(negedge clk);
      assert (halted && !wbEn) else begin
        otherErrors++;
        $display("case %0d: activity after halt at %0t", caseNo, $time);
      end
    end
    assert (seen == expReg.size()) else begin
      otherErrors++;
      $display("case %0d: halted after %0d of %0d expected write-backs",
               caseNo, seen, expReg.size());
    end
    @(posedge clk);
    run <= 1'b0;
  endtask

  // cycle budget from the number of cases
  initial begin
    int cycleCount;
    cycleCount = 0;
    wait (cycleLimit > 0);
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    otherErrors++;
    $display("timeout: run did not finish within %0d cycles", cycleLimit);
    printCounts();
    $display("tests failed");
    $finish;
  end

  initial begin
    restart <= 1'b0;
    run <= 1'b0;
    imemWe <= 1'b0;
    imemAddr <= '0;
    imemData <= '0;
    for (int i = 0; i < imageDepth; i++) begin
      image[i] = 16'h0;
    end
    $readmemh("bench/cpuCases.txt", image);
    numCases = countCases();
    cycleLimit = cyclesPerCase * numCases;
    assert (numCases > 0) else begin
      otherErrors++;
      $display("no complete case found in the cases file");
    end
    for (int c = 1; c <= numCases; c++) begin
      gatherCase();
      resetCore();
      loadProgram(c);
      runProgram(c);
    end
    printCounts();
    if ((mismatches == 0) && (otherErrors == 0)) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end
endmodule

`default_nettype wire

// File: all.f
rtl/cpuPkg.sv
rtl/isaPkg.sv
rtl/ctrlBus.sv
rtl/control.sv
rtl/fetchUnit.sv
rtl/regFile.sv
rtl/alu.sv
rtl/dataMem.sv
rtl/cpuTop.sv
bench/tbClock.sv
bench/cpuTb.sv

// File: run.sh
#!/bin/sh
# builds the core and its testbench with Verilator, runs it, then checks the log

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --assert -j 0 --top-module cpuTb -f all.f --Mdir "$buildDir" -o cpuTb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$buildDir/cpuTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "all tests passed" "$logFile"; then
  exit 0
fi
echo "pass line not found in $logFile"
exit 1

// File: bench/cpuCases.txt
// records of three hex words: kind, address or register, value
// kind 1 loads an instruction, kind 2 is the next expected write-back, kind 3 ends a case
// case 1: saturating add/sub, xor, red, r0 stays zero
1 00 b1ff  2 1 00ff
1 01 a17f  2 1 7fff
1 02 b201  2 2 0001
1 03 0312  2 3 7fff
1 04 b400  2 4 0000
1 05 a480  2 4 8000
1 06 1542  2 5 8000
1 07 1612  2 6 7ffe
1 08 3714  2 7 ffff
1 09 0011  2 0 7fff
1 0a 0802  2 8 0001
1 0b 2910  2 9 0004
1 0c 2a40  2 a fff8
1 0d f000  3 0 0
// case 2: shifts by immediate, paddsb nibble saturation
1 00 b181  2 1 0081
1 01 a1c3  2 1 c381
1 02 4214  2 2 3810
1 03 5314  2 3 fc38
1 04 6418  2 4 81c3
1 05 6510  2 5 c381
1 06 561f  2 6 ffff
1 07 b737  2 7 0037
1 08 a758  2 7 5837
1 09 b82e  2 8 002e
1 0a a849  2 8 492e
1 0b 7978  2 9 7855
1 0c f000  3 0 0
// case 3: stores and loads at several offsets, lhb before llb
1 00 b110  2 1 0010
1 01 b2cd  2 2 00cd
1 02 a2ab  2 2 abcd
1 03 a312  2 3 1200
1 04 b334  2 3 1234
1 05 9210  1 06 9312  1 07 921f
1 08 8410  2 4 abcd
1 09 8512  2 5 1234
1 0a 861f  2 6 abcd
1 0b 9510  1 0c 8710  2 7 1234
1 0d f000  3 0 0
// case 4: each branch with the marker after it, skipped when taken
1 00 b105  2 1 0005
1 01 b205  2 2 0005
1 02 b303  2 3 0003
1 03 1412  2 4 0000
1 04 c201  1 05 ba01
1 06 c001  1 07 ba02  2 a 0002
1 08 c401  1 09 bb03  2 b 0003
1 0a c801  1 0b bb04
1 0c ca01  1 0d bb05
1 0e 1531  2 5 fffe
1 0f c601  1 10 bc06
1 11 c401  1 12 bc07  2 c 0007
1 13 cc01  1 14 bd08  2 d 0008
1 15 a680  2 6 8000
1 16 1763  2 7 8000
1 17 cc01  1 18 bd09
1 19 ce01  1 1a bd0a
1 1b 3812  2 8 0000
1 1c c201  1 1d be0b
1 1e e900  2 9 001f
1 1f bf24  2 f 0024
1 20 d0f0  1 21 be0d  2 e 000d
1 22 def0  1 23 be0e
1 24 f000  3 0 0
// case 5: nothing after hlt executes
1 00 b101  2 1 0001
1 01 f000  1 02 b202
3 0 0
